/* src/mbus_pkg.sv */
package mbus_pkg;

	// ------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------
	localparam int ADDR_W     = 23;
	localparam int DATA_W     = 16;
	localparam int ROM_ADDR_W = 24;
	localparam int BANK_W     = 5;
	localparam int NUM_BANKS  = 8;

	// Banked view of a word address
	localparam int SLOT_W     = $clog2(NUM_BANKS);
	localparam int SLOT_OFS_W = 18;

	localparam logic [DATA_W-1:0] OPEN_BUS_INIT = 16'h4E71;

	// ------------------------------------------------------------
	// Region bounds as word addresses
	// ------------------------------------------------------------
	// Byte address A00000
	localparam logic [ADDR_W-1:0] ROM_AREA_END  = 23'h500000;
	// Byte address A130F0
	localparam logic [ADDR_W-1:0] BANK_REG_BASE = 23'h509878;
	// Byte address E00000
	localparam logic [ADDR_W-1:0] RAM_AREA_BASE = 23'h700000;
	// 2 MiB counted in words like rom_size
	localparam logic [ROM_ADDR_W-1:0] BANK_ENABLE_SIZE = 24'h100000;

	typedef logic [DATA_W-1:0] word_t;

	typedef enum logic {
		SRC_CPU = 1'b0,
		SRC_DMA = 1'b1
	} mbus_src_e;

	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_SELECT     = 3'd1,
		ST_ROM_WAIT   = 3'd2,
		ST_RAM_ACCESS = 3'd3
	} mbus_state_e;

	// One bus word address, read flat or as mapper slot plus offset
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		struct packed {
			logic [ADDR_W-SLOT_W-SLOT_OFS_W-1:0] high;
			logic [SLOT_W-1:0]                   slot;
			logic [SLOT_OFS_W-1:0]               offset;
		} banked;
	} mbus_addr_u;

endpackage

/* src/mbus_request.sv */
module mbus_request (
	input  logic                        MCLK,
	input  logic                        reset,
	input  logic                        cpu_as_n,
	input  logic [mbus_pkg::ADDR_W-1:0] cpu_addr,
	input  mbus_pkg::word_t             cpu_wdata,
	input  logic                        cpu_rnw,
	input  logic                        cpu_uds_n,
	input  logic                        cpu_lds_n,
	input  logic                        dma_sel,
	input  logic [mbus_pkg::ADDR_W-1:0] dma_addr,
	input  logic                        busy_cpu,
	input  logic                        busy_dma,
	input  logic                        cyc_done,
	output logic                        cyc_start,
	output mbus_pkg::mbus_addr_u        cyc_addr,
	output mbus_pkg::word_t             cyc_wdata,
	output logic                        cyc_rnw,
	output logic                        cyc_uds_n,
	output logic                        cyc_lds_n,
	output mbus_pkg::mbus_src_e         cyc_src
);

	logic cyc_open;
	logic cpu_req;
	logic dma_req;

	// A master only asks while its acknowledge is not held
	assign cpu_req = ~cpu_as_n & ~busy_cpu;
	assign dma_req = dma_sel & ~busy_dma;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cyc_open  <= 1'b0;
			cyc_start <= 1'b0;
			cyc_src   <= mbus_pkg::SRC_CPU;
		end else begin
			cyc_start <= 1'b0;
			if (cyc_open) begin
				if (cyc_done) begin
					cyc_open <= 1'b0;
				end
			end else if (cpu_req | dma_req) begin
				cyc_open  <= 1'b1;
				cyc_start <= 1'b1;
				// CPU always wins
				cyc_src   <= cpu_req ? mbus_pkg::SRC_CPU : mbus_pkg::SRC_DMA;
			end
		end
	end

	// Cycle fields latched on a grant and held until the next one
	always_ff @(posedge MCLK) begin
		if (~cyc_open & cpu_req) begin
			cyc_addr.flat <= cpu_addr;
			cyc_wdata     <= cpu_wdata;
			cyc_rnw       <= cpu_rnw;
			cyc_uds_n     <= cpu_uds_n;
			cyc_lds_n     <= cpu_lds_n;
		end else if (~cyc_open & dma_req) begin
			// DMA only reads whole words
			cyc_addr.flat <= dma_addr;
			cyc_rnw       <= 1'b1;
			cyc_uds_n     <= 1'b0;
			cyc_lds_n     <= 1'b0;
		end
	end

	// Control only finishes a cycle that is open
	assert property (@(posedge MCLK) disable iff (reset)
		cyc_done |-> (cyc_open && !cyc_start));

endmodule

/* src/mbus_control.sv */
module mbus_control (
	input  logic                            MCLK,
	input  logic                            reset,
	input  logic                            cyc_start,
	input  mbus_pkg::mbus_addr_u            cyc_addr,
	input  mbus_pkg::word_t                 cyc_wdata,
	input  logic                            cyc_rnw,
	input  logic                            cyc_uds_n,
	input  logic                            cyc_lds_n,
	input  mbus_pkg::mbus_src_e             cyc_src,
	input  logic [mbus_pkg::ROM_ADDR_W-1:0] rom_size,
	input  mbus_pkg::word_t                 open_bus,
	input  mbus_pkg::word_t                 ram_rdata,
	input  mbus_pkg::word_t                 rom_rdata,
	input  logic                            rom_ack,
	input  logic [mbus_pkg::ROM_ADDR_W-1:0] rom_addr_mapped,
	output logic                            ram_we_hi,
	output logic                            ram_we_lo,
	output logic                            bank_we,
	output logic                            rom_req,
	output logic                            cyc_done,
	output mbus_pkg::word_t                 cyc_rdata,
	output mbus_pkg::mbus_src_e             done_src,
	output logic                            fill_open_bus
);

	mbus_pkg::mbus_state_e state;

	logic in_rom_area;
	logic in_ram_area;
	logic in_bank_win;
	logic rom_in_size;
	logic bank_write;

	// ------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------
	always_comb begin
		in_rom_area = cyc_addr.flat < mbus_pkg::ROM_AREA_END;
		in_ram_area = cyc_addr.flat >= mbus_pkg::RAM_AREA_BASE;
		in_bank_win = cyc_addr.flat[mbus_pkg::ADDR_W-1:3] ==
			mbus_pkg::BANK_REG_BASE[mbus_pkg::ADDR_W-1:3];
		// Checked after mapping so a bank pointing past the image reads 0
		rom_in_size = rom_addr_mapped < rom_size;
		// Small cartridges have no mapper, slot 0 is hardwired
		bank_write  = in_bank_win & ~cyc_rnw &
			(rom_size > mbus_pkg::BANK_ENABLE_SIZE) &
			(cyc_addr.flat[mbus_pkg::SLOT_W-1:0] != '0);
	end

	assign bank_we   = (state == mbus_pkg::ST_SELECT) & ~in_rom_area & ~in_ram_area &
		bank_write;
	assign ram_we_hi = (state == mbus_pkg::ST_RAM_ACCESS) & ~cyc_rnw & ~cyc_uds_n;
	assign ram_we_lo = (state == mbus_pkg::ST_RAM_ACCESS) & ~cyc_rnw & ~cyc_lds_n;

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state         <= mbus_pkg::ST_IDLE;
			rom_req       <= 1'b0;
			cyc_done      <= 1'b0;
			fill_open_bus <= 1'b0;
		end else begin
			cyc_done      <= 1'b0;
			fill_open_bus <= 1'b0;
			case (state)
				mbus_pkg::ST_IDLE: begin
					if (cyc_start) begin
						state <= mbus_pkg::ST_SELECT;
					end
				end
				mbus_pkg::ST_SELECT: begin
					if (in_rom_area & rom_in_size & cyc_rnw) begin
						// Toggle starts the external read
						rom_req <= ~rom_ack;
						state   <= mbus_pkg::ST_ROM_WAIT;
					end else if (in_rom_area) begin
						cyc_done <= 1'b1;
						state    <= mbus_pkg::ST_IDLE;
					end else if (in_ram_area) begin
						state <= mbus_pkg::ST_RAM_ACCESS;
					end else begin
						// Bank window or nothing
						cyc_done <= 1'b1;
						state    <= mbus_pkg::ST_IDLE;
					end
				end
				mbus_pkg::ST_ROM_WAIT: begin
					if (rom_req == rom_ack) begin
						cyc_done      <= 1'b1;
						fill_open_bus <= cyc_src == mbus_pkg::SRC_CPU;
						state         <= mbus_pkg::ST_IDLE;
					end
				end
				mbus_pkg::ST_RAM_ACCESS: begin
					cyc_done      <= 1'b1;
					fill_open_bus <= cyc_rnw & (cyc_src == mbus_pkg::SRC_CPU);
					state         <= mbus_pkg::ST_IDLE;
				end
				default: begin
					state <= mbus_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Result word
	// ------------------------------------------------------------
	// Write cycles hand back the word driven on the bus
	always_ff @(posedge MCLK) begin
		case (state)
			mbus_pkg::ST_SELECT: begin
				done_src <= cyc_src;
				if (~cyc_rnw) begin
					cyc_rdata <= cyc_wdata;
				end else if (in_rom_area) begin
					cyc_rdata <= '0;
				end else begin
					cyc_rdata <= open_bus;
				end
			end
			mbus_pkg::ST_ROM_WAIT: begin
				cyc_rdata <= rom_rdata;
			end
			mbus_pkg::ST_RAM_ACCESS: begin
				cyc_rdata <= cyc_rnw ? ram_rdata : cyc_wdata;
			end
			default: begin
				cyc_rdata <= cyc_rdata;
			end
		endcase
	end

	// ROM handshake only outstanding while waiting on it
	assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != rom_ack) |-> (state == mbus_pkg::ST_ROM_WAIT));

endmodule

/* src/rom_bank_map.sv */
module rom_bank_map (
	input  logic                            MCLK,
	input  logic                            reset,
	input  mbus_pkg::mbus_addr_u            cyc_addr,
	input  mbus_pkg::word_t                 cyc_wdata,
	input  logic                            bank_we,
	output logic [mbus_pkg::ROM_ADDR_W-1:0] rom_addr
);

	logic [mbus_pkg::BANK_W-1:0] bank_reg [mbus_pkg::NUM_BANKS];
	logic                        bank_mode;

	// Registers start as identity map, slot n holds bank n
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_mode <= 1'b0;
			for (int i = 0; i < mbus_pkg::NUM_BANKS; i++) begin
				bank_reg[i] <= mbus_pkg::BANK_W'(i);
			end
		end else if (bank_we) begin
			bank_reg[cyc_addr.flat[mbus_pkg::SLOT_W-1:0]] <= cyc_wdata[mbus_pkg::BANK_W-1:0];
			bank_mode <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Address mapping
	// ------------------------------------------------------------
	// Mapper covers the low 4 MiB only
	always_comb begin
		if (bank_mode && cyc_addr.banked.high == '0) begin
			rom_addr = mbus_pkg::ROM_ADDR_W'({bank_reg[cyc_addr.banked.slot],
				cyc_addr.banked.offset});
		end else begin
			rom_addr = mbus_pkg::ROM_ADDR_W'(cyc_addr.flat);
		end
	end

	// Slot 0 keeps the vector table in place
	assert property (@(posedge MCLK) disable iff (reset)
		bank_we |-> (cyc_addr.flat[mbus_pkg::SLOT_W-1:0] != '0));

endmodule

/* src/work_ram.sv */
module work_ram #(
	parameter int RAM_ADDR_W = 15
) (
	input  logic                  MCLK,
	input  logic [RAM_ADDR_W-1:0] addr,
	input  mbus_pkg::word_t       wdata,
	input  logic                  we_hi,
	input  logic                  we_lo,
	output mbus_pkg::word_t       rdata
);

	localparam int DEPTH  = 1 << RAM_ADDR_W;
	localparam int BYTE_W = mbus_pkg::DATA_W / 2;

	// One array per byte lane
	logic [BYTE_W-1:0] mem_hi [DEPTH];
	logic [BYTE_W-1:0] mem_lo [DEPTH];

	always_ff @(posedge MCLK) begin
		if (we_hi) begin
			mem_hi[addr] <= wdata[mbus_pkg::DATA_W-1:BYTE_W];
		end
		if (we_lo) begin
			mem_lo[addr] <= wdata[BYTE_W-1:0];
		end
		// Old word on a write, nobody reads it then
		rdata <= {mem_hi[addr], mem_lo[addr]};
	end

endmodule

/* src/mbus_reply.sv */
module mbus_reply (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                cpu_as_n,
	input  logic                dma_sel,
	input  logic                cyc_done,
	input  mbus_pkg::mbus_src_e done_src,
	input  mbus_pkg::word_t     cyc_rdata,
	input  logic                fill_open_bus,
	output logic                cpu_dtack_n,
	output mbus_pkg::word_t     cpu_rdata,
	output logic                dma_dtack_n,
	output mbus_pkg::word_t     dma_rdata,
	output mbus_pkg::word_t     open_bus,
	output logic                busy_cpu,
	output logic                busy_dma
);

	logic done_cpu;
	logic done_dma;

	assign done_cpu = cyc_done & (done_src == mbus_pkg::SRC_CPU);
	assign done_dma = cyc_done & (done_src == mbus_pkg::SRC_DMA);

	// ------------------------------------------------------------
	// Acknowledges and open bus
	// ------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			cpu_dtack_n <= 1'b1;
			dma_dtack_n <= 1'b1;
			open_bus    <= mbus_pkg::OPEN_BUS_INIT;
		end else begin
			// Held until the master lets go of its strobe
			if (done_cpu) begin
				cpu_dtack_n <= 1'b0;
			end else if (cpu_as_n) begin
				cpu_dtack_n <= 1'b1;
			end
			if (done_dma) begin
				dma_dtack_n <= 1'b0;
			end else if (~dma_sel) begin
				dma_dtack_n <= 1'b1;
			end
			if (cyc_done & fill_open_bus) begin
				open_bus <= cyc_rdata;
			end
		end
	end

	// Read words per master
	always_ff @(posedge MCLK) begin
		if (done_cpu) begin
			cpu_rdata <= cyc_rdata;
		end
		if (done_dma) begin
			dma_rdata <= cyc_rdata;
		end
	end

	assign busy_cpu = ~cpu_dtack_n;
	assign busy_dma = ~dma_dtack_n;

endmodule

/* src/mbus_top.sv */
module mbus_top #(
	parameter int RAM_ADDR_W = 15
) (
	input  logic                            MCLK,
	input  logic                            reset,
	input  logic                            cpu_as_n,
	input  logic [mbus_pkg::ADDR_W-1:0]     cpu_addr,
	input  mbus_pkg::word_t                 cpu_wdata,
	input  logic                            cpu_rnw,
	input  logic                            cpu_uds_n,
	input  logic                            cpu_lds_n,
	output logic                            cpu_dtack_n,
	output mbus_pkg::word_t                 cpu_rdata,
	input  logic                            dma_sel,
	input  logic [mbus_pkg::ADDR_W-1:0]     dma_addr,
	output logic                            dma_dtack_n,
	output mbus_pkg::word_t                 dma_rdata,
	// Cartridge size in 16-bit words
	input  logic [mbus_pkg::ROM_ADDR_W-1:0] rom_size,
	output logic [mbus_pkg::ROM_ADDR_W-1:0] rom_addr,
	input  mbus_pkg::word_t                 rom_rdata,
	output logic                            rom_req,
	input  logic                            rom_ack
);

	logic                 cyc_start;
	mbus_pkg::mbus_addr_u cyc_addr;
	mbus_pkg::word_t      cyc_wdata;
	logic                 cyc_rnw;
	logic                 cyc_uds_n;
	logic                 cyc_lds_n;
	mbus_pkg::mbus_src_e  cyc_src;
	logic                 cyc_done;
	mbus_pkg::word_t      cyc_rdata;
	mbus_pkg::mbus_src_e  done_src;
	logic                 fill_open_bus;
	logic                 busy_cpu;
	logic                 busy_dma;
	mbus_pkg::word_t      open_bus;
	mbus_pkg::word_t      ram_rdata;
	logic                 ram_we_hi;
	logic                 ram_we_lo;
	logic                 bank_we;

	mbus_request mbus_request_inst (
		.MCLK(MCLK), .reset(reset),
		.cpu_as_n(cpu_as_n), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rnw(cpu_rnw), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.dma_sel(dma_sel), .dma_addr(dma_addr),
		.busy_cpu(busy_cpu), .busy_dma(busy_dma), .cyc_done(cyc_done),
		.cyc_start(cyc_start), .cyc_addr(cyc_addr), .cyc_wdata(cyc_wdata),
		.cyc_rnw(cyc_rnw), .cyc_uds_n(cyc_uds_n), .cyc_lds_n(cyc_lds_n),
		.cyc_src(cyc_src)
	);

	mbus_control mbus_control_inst (
		.MCLK(MCLK), .reset(reset),
		.cyc_start(cyc_start), .cyc_addr(cyc_addr), .cyc_wdata(cyc_wdata),
		.cyc_rnw(cyc_rnw), .cyc_uds_n(cyc_uds_n), .cyc_lds_n(cyc_lds_n),
		.cyc_src(cyc_src), .rom_size(rom_size), .open_bus(open_bus),
		.ram_rdata(ram_rdata), .rom_rdata(rom_rdata), .rom_ack(rom_ack),
		.rom_addr_mapped(rom_addr), .ram_we_hi(ram_we_hi), .ram_we_lo(ram_we_lo),
		.bank_we(bank_we), .rom_req(rom_req), .cyc_done(cyc_done),
		.cyc_rdata(cyc_rdata), .done_src(done_src), .fill_open_bus(fill_open_bus)
	);

	rom_bank_map rom_bank_map_inst (
		.MCLK(MCLK), .reset(reset),
		.cyc_addr(cyc_addr), .cyc_wdata(cyc_wdata), .bank_we(bank_we),
		.rom_addr(rom_addr)
	);

	// Low address bits only, so the RAM mirrors over its whole area
	work_ram #(.RAM_ADDR_W(RAM_ADDR_W)) work_ram_inst (
		.MCLK(MCLK), .addr(cyc_addr.flat[RAM_ADDR_W-1:0]), .wdata(cyc_wdata),
		.we_hi(ram_we_hi), .we_lo(ram_we_lo), .rdata(ram_rdata)
	);

	mbus_reply mbus_reply_inst (
		.MCLK(MCLK), .reset(reset),
		.cpu_as_n(cpu_as_n), .dma_sel(dma_sel), .cyc_done(cyc_done),
		.done_src(done_src), .cyc_rdata(cyc_rdata), .fill_open_bus(fill_open_bus),
		.cpu_dtack_n(cpu_dtack_n), .cpu_rdata(cpu_rdata),
		.dma_dtack_n(dma_dtack_n), .dma_rdata(dma_rdata),
		.open_bus(open_bus), .busy_cpu(busy_cpu), .busy_dma(busy_dma)
	);

endmodule

/* test/tb_mbus_model.svh */
`ifndef TB_MBUS_MODEL_SVH
`define TB_MBUS_MODEL_SVH

// Reference state, advanced in the order the DUT acknowledges cycles
mbus_pkg::word_t             model_ram [1 << RAM_ADDR_W];
logic [mbus_pkg::BANK_W-1:0] model_bank [mbus_pkg::NUM_BANKS];
logic                        model_bank_mode;
mbus_pkg::word_t             model_open_bus;

// Cartridge image content at a ROM word address
function automatic mbus_pkg::word_t rom_word(input logic [23:0] addr);
	return addr[15:0] ^ 16'hA5C3;
endfunction

function automatic void reset_model();
	for (int i = 0; i < mbus_pkg::NUM_BANKS; i++) begin
		model_bank[i] = 5'(i);
	end
	model_bank_mode = 1'b0;
	model_open_bus  = 16'h4E71;
endfunction

// 512 KiB slots, switched only in the low 4 MiB
function automatic logic [23:0] mapped_rom_addr(input logic [22:0] addr);
	if (model_bank_mode && addr < 23'h200000) begin
		return {1'b0, model_bank[addr[20:18]], addr[17:0]};
	end
	return {1'b0, addr};
endfunction

function automatic mbus_pkg::word_t expect_read(input logic [22:0] addr);
	logic [23:0] rom_word_addr;
	rom_word_addr = mapped_rom_addr(addr);
	// Cartridge area ends at byte A00000
	if (addr < 23'h500000) begin
		return (rom_word_addr < rom_size) ? rom_word(rom_word_addr) : 16'h0000;
	end
	// Work RAM from byte E00000 up, mirrored
	if (addr >= 23'h700000) begin
		return model_ram[addr[RAM_ADDR_W-1:0]];
	end
	return model_open_bus;
endfunction

// Only CPU reads that reach ROM or RAM leave a word on the bus
function automatic void note_cpu_read(input logic [22:0] addr, input mbus_pkg::word_t value);
	if ((addr < 23'h500000 && mapped_rom_addr(addr) < rom_size) || addr >= 23'h700000) begin
		model_open_bus = value;
	end
endfunction

function automatic void model_write(input logic [22:0] addr, input mbus_pkg::word_t data,
	input logic uds_n, input logic lds_n);
	if (addr >= 23'h700000) begin
		if (!uds_n) begin
			model_ram[addr[RAM_ADDR_W-1:0]][15:8] = data[15:8];
		end
		if (!lds_n) begin
			model_ram[addr[RAM_ADDR_W-1:0]][7:0] = data[7:0];
		end
	end else if (addr[22:3] == 20'hA130F && addr[2:0] != 3'd0 && rom_size > 24'h100000) begin
		// Bank window A130F0, mapper only above 2 MiB
		model_bank[addr[2:0]] = data[4:0];
		model_bank_mode       = 1'b1;
	end
endfunction

`endif

/* test/tb_mbus.sv */
module tb_mbus;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_ADDR_W = 15;

	logic                            MCLK;
	logic                            reset;
	logic                            cpu_as_n;
	logic [mbus_pkg::ADDR_W-1:0]     cpu_addr;
	mbus_pkg::word_t                 cpu_wdata;
	logic                            cpu_rnw;
	logic                            cpu_uds_n;
	logic                            cpu_lds_n;
	logic                            cpu_dtack_n;
	mbus_pkg::word_t                 cpu_rdata;
	logic                            dma_sel;
	logic [mbus_pkg::ADDR_W-1:0]     dma_addr;
	logic                            dma_dtack_n;
	mbus_pkg::word_t                 dma_rdata;
	logic [mbus_pkg::ROM_ADDR_W-1:0] rom_size;
	logic [mbus_pkg::ROM_ADDR_W-1:0] rom_addr;
	mbus_pkg::word_t                 rom_rdata = '0;
	logic                            rom_req;
	logic                            rom_ack = 1'b0;

	int errors      = 0;
	int checks      = 0;
	int issued      = 0;
	int cpu_issued  = 0;
	int dma_issued  = 0;
	int cpu_acks    = 0;
	int dma_acks    = 0;
	int cycle_count = 0;
	int rom_wait    = 0;

	`include "tb_mbus_model.svh"

	mbus_top #(.RAM_ADDR_W(RAM_ADDR_W)) mbus_top_inst (.*);

	initial begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	always @(posedge MCLK) cycle_count <= cycle_count + 1;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error: %s is %0h, expected %0h", name, got, expected);
		end
	endtask

	// ------------------------------------------------------------
	// Bus masters
	// ------------------------------------------------------------
	task automatic cpu_access(input logic [22:0] addr, input logic rnw,
		input mbus_pkg::word_t data, input logic [1:0] lanes_n);
		issued++;
		cpu_issued++;
		@(posedge MCLK);
		cpu_addr  <= addr;
		cpu_rnw   <= rnw;
		cpu_wdata <= data;
		cpu_uds_n <= lanes_n[1];
		cpu_lds_n <= lanes_n[0];
		cpu_as_n  <= 1'b0;
		@(posedge MCLK);
		while (cpu_dtack_n) @(posedge MCLK);
		cpu_as_n <= 1'b1;
		@(posedge MCLK);
		while (!cpu_dtack_n) @(posedge MCLK);
	endtask

	task automatic dma_fetch(input logic [22:0] addr);
		issued++;
		dma_issued++;
		@(posedge MCLK);
		dma_addr <= addr;
		dma_sel  <= 1'b1;
		@(posedge MCLK);
		while (dma_dtack_n) @(posedge MCLK);
		dma_sel <= 1'b0;
		@(posedge MCLK);
		while (!dma_dtack_n) @(posedge MCLK);
	endtask

	// Pool of 16 RAM words spaced apart and seen through one of 32 mirrors
	function automatic logic [22:0] ram_mirror_addr(input int idx, input logic [4:0] mirror);
		return {3'b111, mirror, 15'(idx * 1043)};
	endfunction

	function automatic logic [22:0] random_addr();
		case ($urandom_range(0, 4))
			0, 1: return 23'($urandom_range(0, 24'h1FFFFF));
			2: return 23'($urandom_range(24'h200000, 24'h4FFFFF));
			3: return ram_mirror_addr($urandom_range(0, 15), 5'($urandom));
			default: return 23'($urandom_range(24'h500000, 24'h6FFFFF));
		endcase
	endfunction

	task automatic random_cpu_op();
		int kind;
		kind = $urandom_range(0, 7);
		if (kind == 0) begin
			cpu_access(ram_mirror_addr($urandom_range(0, 15), 5'($urandom)), 1'b0,
				mbus_pkg::word_t'($urandom), 2'($urandom));
		end else if (kind == 1) begin
			cpu_access(23'h509878 + 23'($urandom_range(1, 7)), 1'b0,
				mbus_pkg::word_t'($urandom_range(0, 7)), 2'b00);
		end else begin
			cpu_access(random_addr(), 1'b1, '0, 2'b00);
		end
	endtask

	// ROM responder answers after 1 to 4 cycles
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack  <= 1'b0;
			rom_wait <= 0;
		end else if (rom_wait == 1) begin
			rom_ack   <= rom_req;
			rom_rdata <= rom_word(rom_addr);
			rom_wait  <= 0;
		end else if (rom_wait > 1) begin
			rom_wait <= rom_wait - 1;
		end else if (rom_req != rom_ack) begin
			rom_wait <= $urandom_range(1, 4);
		end
	end

	// ------------------------------------------------------------
	// Compare against the reference on each new acknowledge
	// ------------------------------------------------------------
	initial begin : compare
		logic            cpu_acked;
		logic            dma_acked;
		mbus_pkg::word_t expected;
		cpu_acked = 1'b0;
		dma_acked = 1'b0;
		forever begin
			@(posedge MCLK);
			if (!reset) begin
				if (!cpu_dtack_n && !cpu_acked) begin
					cpu_acks++;
					if (cpu_as_n) begin
						errors++;
						$display("CPU acknowledge arrived with no cycle pending");
					end else if (cpu_rnw) begin
						expected = expect_read(cpu_addr);
						check_value("cpu_rdata", 32'(cpu_rdata), 32'(expected));
						note_cpu_read(cpu_addr, expected);
					end else begin
						model_write(cpu_addr, cpu_wdata, cpu_uds_n, cpu_lds_n);
					end
				end
				if (!dma_dtack_n && !dma_acked) begin
					dma_acks++;
					if (!dma_sel) begin
						errors++;
						$display("DMA acknowledge arrived with no request pending");
					end else begin
						check_value("dma_rdata", 32'(dma_rdata), 32'(expect_read(dma_addr)));
					end
				end
				cpu_acked = !cpu_dtack_n;
				dma_acked = !dma_dtack_n;
			end
		end
	end

	initial begin : watchdog
		wait (cycle_count > 40 * issued + 200);
		$display("Timeout: no acknowledge after %0d cycles", cycle_count);
		$display("Regression failed");
		$finish;
	end

	initial begin : stimulus
		int i;
		int j;
		int k;
		void'($urandom(62887));
		reset_model();
		reset     = 1'b1;
		cpu_as_n  = 1'b1;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_rnw   = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		dma_sel   = 1'b0;
		dma_addr  = '0;
		// 2 MiB cartridge counted in words
		rom_size  = 24'h100000;
		repeat (4) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);

		check_value("cpu_dtack_n", 32'(cpu_dtack_n), 32'd1);
		check_value("dma_dtack_n", 32'(dma_dtack_n), 32'd1);
		check_value("rom_req", 32'(rom_req), 32'(rom_ack));
		// Byte A20000 is unmapped
		cpu_access(23'h510000, 1'b1, '0, 2'b00);
		check_value("cpu_rdata", 32'(cpu_rdata), 32'h4E71);

		// Full RAM words first so nothing reads uninitialized
		for (i = 0; i < 16; i++) begin
			cpu_access(ram_mirror_addr(i, 5'd0), 1'b0, mbus_pkg::word_t'($urandom), 2'b00);
		end
		for (i = 0; i < 24; i++) begin
			cpu_access(ram_mirror_addr(i % 16, 5'($urandom)), 1'b0,
				mbus_pkg::word_t'($urandom), 2'($urandom));
		end
		for (i = 0; i < 16; i++) begin
			cpu_access(ram_mirror_addr(i, 5'd0), 1'b1, '0, 2'b00);
			cpu_access(ram_mirror_addr(i, 5'($urandom)), 1'b1, '0, 2'b00);
		end

		// ROM reads inside and past the cartridge, then a write that goes nowhere
		for (i = 0; i < 12; i++) begin
			cpu_access(23'($urandom_range(0, 24'h0FFFFF)), 1'b1, '0, 2'b00);
		end
		for (i = 0; i < 6; i++) begin
			cpu_access(23'($urandom_range(24'h100000, 24'h4FFFFF)), 1'b1, '0, 2'b00);
		end
		cpu_access(23'h000123, 1'b0, 16'hDEAD, 2'b00);
		cpu_access(23'h000123, 1'b1, '0, 2'b00);

		// Bank writes ignored at 2 MiB and live at 4 MiB
		for (k = 0; k < 2; k++) begin
			// Bank numbers up to 15, so about half land past a 4 MiB image
			for (i = 1; i < 8; i++) begin
				cpu_access(23'h509878 + 23'(i), 1'b0,
					mbus_pkg::word_t'(($urandom & 32'hFFE0) | $urandom_range(0, 15)), 2'b00);
			end
			for (i = 0; i < 16; i++) begin
				cpu_access({2'b00, 3'(i), 18'($urandom)}, 1'b1, '0, 2'b00);
			end
			rom_size <= 24'h200000;
			@(posedge MCLK);
		end
		// Slot pointing past the image reads zero
		cpu_access(23'h50987F, 1'b0, 16'h001F, 2'b00);
		cpu_access(23'h1C0040, 1'b1, '0, 2'b00);

		// Open bus follows CPU reads only
		cpu_access(23'h001000, 1'b1, '0, 2'b00);
		dma_fetch(23'h510000);
		check_value("dma_rdata", 32'(dma_rdata), 32'(rom_word(24'h001000)));
		dma_fetch(23'h002000);
		dma_fetch(23'h600000);
		cpu_access(ram_mirror_addr(3, 5'd0), 1'b1, '0, 2'b00);
		cpu_access(23'h6ABCDE, 1'b1, '0, 2'b00);
		dma_fetch(23'h50987C);

		fork
			for (j = 0; j < 60; j++) begin
				random_cpu_op();
			end
			for (k = 0; k < 60; k++) begin
				repeat ($urandom_range(0, 3)) @(posedge MCLK);
				dma_fetch(random_addr());
			end
		join

		repeat (4) @(posedge MCLK);
		check_value("cpu acknowledges", 32'(cpu_acks), 32'(cpu_issued));
		check_value("dma acknowledges", 32'(dma_acks), 32'(dma_issued));
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+test
src/mbus_pkg.sv
src/mbus_request.sv
src/mbus_control.sv
src/rom_bank_map.sv
src/work_ram.sv
src/mbus_reply.sv
src/mbus_top.sv
test/tb_mbus.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module tb_mbus \
	-o tb_mbus_sim

./obj_dir/tb_mbus_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
exit 0
